//--- all.f
+incdir+tb
hdl/action_pkg.sv
hdl/operand_locator.sv
hdl/operand_fetch.sv
hdl/kv_ram.sv
hdl/alu_writeback.sv
hdl/action_engine.sv
tb/tb_action_engine.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_action_engine
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST)) tb/action_vectors.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/action_vectors.svh
`ifndef ACTION_VECTORS_SVH
`define ACTION_VECTORS_SVH

// one table entry holds the action, its valid flag and the idle cycles after it
typedef struct packed {
    action_t    act;
    logic       valid;
    logic [3:0] gap;
} vec_t;

// header bytes come from the lcg started here
localparam logic [31:0] LCG_SEED = 32'd19;
localparam int NUM_VECS = 23;

// byte offsets of slots 0..7, for 2-, 4- and 8-byte fields in that order
localparam logic [7:0] OFF_TBL [24] = '{
    8'd0,  8'd2,  8'd4,  8'd6,  8'd8,  8'd10, 8'd12, 8'd14,
    8'd16, 8'd20, 8'd24, 8'd28, 8'd32, 8'd36, 8'd40, 8'd44,
    8'd0,  8'd8,  8'd16, 8'd24, 8'd32, 8'd40, 8'd48, 8'd56
};

vec_t vecs [NUM_VECS];

function automatic action_t arith_action(logic [3:0] op, logic [1:0] w, logic [2:0] a,
                                         logic [2:0] b);
    return action_t'({op, w, a, w, b, 11'd0});
endfunction

// immediate or memory address in the low 16 bits
function automatic action_t imm_action(logic [3:0] op, logic [1:0] w, logic [2:0] s,
                                       logic [15:0] v);
    return action_t'({op, w, s, v});
endfunction

function automatic action_t ctl_action(logic [3:0] op, logic [7:0] port, logic drop);
    return action_t'({op, port, drop, 12'd0});
endfunction

task automatic fill_vectors();
    vecs[0]  = '{arith_action(op_add, w2, 3'd0, 3'd1), 1'b1, 4'd1};
    vecs[1]  = '{arith_action(op_sub, w2, 3'd2, 3'd3), 1'b1, 4'd0};
    vecs[2]  = '{imm_action(op_addi, w2, 3'd4, 16'hffff), 1'b1, 4'd0};
    vecs[3]  = '{imm_action(op_subi, w2, 3'd5, 16'h1234), 1'b1, 4'd2};
    vecs[4]  = '{arith_action(op_add, w4, 3'd0, 3'd1), 1'b1, 4'd0};
    vecs[5]  = '{arith_action(op_sub, w4, 3'd2, 3'd3), 1'b1, 4'd0};
    vecs[6]  = '{imm_action(op_addi, w4, 3'd4, 16'hbeef), 1'b1, 4'd0};
    vecs[7]  = '{imm_action(op_subi, w4, 3'd6, 16'hffff), 1'b1, 4'd1};
    vecs[8]  = '{arith_action(op_add, w8, 3'd0, 3'd7), 1'b1, 4'd0};
    vecs[9]  = '{arith_action(op_sub, w8, 3'd1, 3'd2), 1'b1, 4'd0};
    vecs[10] = '{imm_action(op_addi, w8, 3'd3, 16'h8001), 1'b1, 4'd0};
    vecs[11] = '{imm_action(op_subi, w8, 3'd4, 16'h00ff), 1'b1, 4'd3};
    vecs[12] = '{ctl_action(op_redirect, 8'h5a, 1'b0), 1'b1, 4'd0};
    vecs[13] = '{ctl_action(op_discard, 8'h00, 1'b1), 1'b1, 4'd2};
    vecs[14] = '{imm_action(op_store, w4, 3'd2, 16'd7), 1'b1, 4'd0};
    vecs[15] = '{imm_action(op_load, w4, 3'd5, 16'd7), 1'b1, 4'd1};
    vecs[16] = '{imm_action(op_store, w4, 3'd1, 16'd19), 1'b1, 4'd3};
    vecs[17] = '{imm_action(op_load, w4, 3'd6, 16'd19), 1'b1, 4'd0};
    vecs[18] = '{imm_action(4'd7, w2, 3'd0, 16'h0000), 1'b1, 4'd0};
    vecs[19] = '{imm_action(op_addi, w4, 3'd3, 16'h0042), 1'b1, 4'd0};
    vecs[20] = '{imm_action(4'd15, w2, 3'd1, 16'h0000), 1'b1, 4'd0};
    vecs[21] = '{arith_action(op_add, w2, 3'd6, 3'd7), 1'b0, 4'd0};
    vecs[22] = '{imm_action(op_load, w4, 3'd0, 16'd7), 1'b1, 4'd0};
endtask

`endif

//--- tb/tb_action_engine.sv
`timescale 1ns/1ns
module tb_action_engine;

    import action_pkg::*;

    localparam int LATENCY = 3;

    typedef struct packed {
        phv_t        phv;
        logic [31:0] cyc;
        logic [7:0]  idx;
        logic        emit;
    } exp_t;

    logic    axis_clk;
    logic    aresetn;
    action_t action_in;
    logic    action_in_valid;
    phv_t    phv_in;
    phv_t    phv_out;
    logic    phv_out_valid;

    logic [31:0] rng_state;
    logic [31:0] kv_model [KV_DEPTH];
    exp_t        exp_q [$];
    int          edge_cnt;
    int          pass_cnt;
    int          err_cnt;

    `include "action_vectors.svh"

    action_engine i_dut (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .action_in       (action_in),
        .action_in_valid (action_in_valid),
        .phv_in          (phv_in),
        .phv_out         (phv_out),
        .phv_out_valid   (phv_out_valid)
    );

    always #50 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [63:0] read_field(hdr_t h, int off, int n);
        hdr_t        sh;
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            sh = h << (8 * (off + i));
            v = {v[55:0], sh[HDR_BITS-1 -: 8]};
        end
        return v;
    endfunction

    // lowest byte of v goes to the last byte of the field
    function automatic hdr_t write_field(hdr_t h, int off, int n, logic [63:0] v);
        hdr_t        r;
        logic [63:0] d;
        int          pos;
        int          i;
        r = h;
        d = v;
        for (i = n - 1; i >= 0; i--) begin
            pos = 8 * (HDR_BYTES - 1 - off - i);
            r = (r & ~(hdr_t'(8'hff) << pos)) | (hdr_t'(d[7:0]) << pos);
            d = d >> 8;
        end
        return r;
    endfunction

    task automatic make_phv(output phv_t p);
        int i;
        p = '0;
        for (i = 0; i < HDR_BYTES; i++) begin
            rng_state = lcg_step(rng_state);
            p.hdr = {p.hdr[HDR_BITS-9:0], rng_state[23:16]};
        end
        rng_state = lcg_step(rng_state);
        p.meta = rng_state;
        for (i = 0; i < 3 * OFF_SLOTS; i++) begin
            p.tbl = {p.tbl[183:0], OFF_TBL[i]};
        end
    endtask

    task automatic apply_model(input action_t a, input phv_t p, output phv_t e,
                               output logic emits);
        int          n;
        int          o1;
        int          o2;
        logic [63:0] x;
        logic [63:0] y;
        logic [4:0]  addr;
        e = p;
        emits = 1'b1;
        // 2, 4 or 8 bytes
        n = 2 << a.op1_width;
        o1 = int'(OFF_TBL[a.op1_width * 8 + a.op1_slot]);
        o2 = int'(OFF_TBL[a.op2_width * 8 + a.op2_slot]);
        addr = a[4:0];
        x = read_field(p.hdr, o1, n);
        y = 64'(a[15:0]);
        case (a.opcode)
            op_add:      e.hdr = write_field(p.hdr, o1, n, x + read_field(p.hdr, o2, n));
            op_sub:      e.hdr = write_field(p.hdr, o1, n, x - read_field(p.hdr, o2, n));
            op_addi:     e.hdr = write_field(p.hdr, o1, n, x + y);
            op_subi:     e.hdr = write_field(p.hdr, o1, n, x - y);
            op_store:    kv_model[addr] = 32'(read_field(p.hdr, o1, 4));
            op_load:     e.hdr = write_field(p.hdr, o1, 4, 64'(kv_model[addr]));
            op_redirect: e.meta.port = a[20:13];
            op_discard:  e.meta.drop = a[12];
            default:     emits = 1'b0;
        endcase
    endtask

    task automatic check_output(exp_t x);
        logic [3:0] op;
        op = vecs[x.idx].act.opcode;
        if (!x.emit) begin
            if (phv_out_valid) begin
                err_cnt++;
                $display("test %0d (opcode %0d): output seen where none was due", x.idx, op);
            end else begin
                pass_cnt++;
                $display("test %0d (opcode %0d): no output, ok", x.idx, op);
            end
        end else if (!phv_out_valid) begin
            err_cnt++;
            $display("test %0d (opcode %0d): no output at cycle %0d", x.idx, op, x.cyc);
        end else if (phv_out !== x.phv) begin
            err_cnt++;
            $display("FAILED at %0t: test %0d (opcode %0d) hdr %h meta %h, expected hdr %h meta %h",
                     $time, x.idx, op, phv_out.hdr, phv_out.meta, x.phv.hdr, x.phv.meta);
        end else begin
            pass_cnt++;
            $display("test %0d (opcode %0d): ok", x.idx, op);
        end
    endtask

    // outputs sampled at the falling edge
    always @(negedge axis_clk) begin
        exp_t x;
        if (exp_q.size() != 0 && exp_q[0].cyc == edge_cnt) begin
            x = exp_q.pop_front();
            check_output(x);
        end else if (phv_out_valid) begin
            err_cnt++;
            $display("phv_out_valid high at %0t with no action due in this cycle", $time);
        end
    end

    initial begin
        int limit;
        int i;
        @(posedge aresetn);
        limit = NUM_VECS + 20;
        for (i = 0; i < NUM_VECS; i++) begin
            limit += int'(vecs[i].gap);
        end
        repeat (limit) @(posedge axis_clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

    initial begin
        phv_t p;
        phv_t e;
        logic emits;
        exp_t x;
        int   i;
        axis_clk = 1'b0;
        aresetn = 1'b0;
        action_in = '0;
        action_in_valid = 1'b0;
        phv_in = '0;
        edge_cnt = 0;
        pass_cnt = 0;
        err_cnt = 0;
        rng_state = LCG_SEED;
        fill_vectors();
        repeat (3) @(posedge axis_clk);
        aresetn <= 1'b1;
        for (i = 0; i < NUM_VECS; i++) begin
            @(posedge axis_clk);
            make_phv(p);
            action_in <= vecs[i].act;
            phv_in <= p;
            action_in_valid <= vecs[i].valid;
            e = p;
            emits = 1'b0;
            if (vecs[i].valid) begin
                apply_model(vecs[i].act, p, e, emits);
            end
            x.phv = e;
            x.cyc = edge_cnt + 1 + LATENCY;
            x.idx = 8'(i);
            x.emit = emits;
            exp_q.push_back(x);
            repeat (vecs[i].gap) begin
                @(posedge axis_clk);
                action_in_valid <= 1'b0;
            end
        end
        @(posedge axis_clk);
        action_in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge axis_clk);
        end
        repeat (2) @(negedge axis_clk);
        $display("summary: %0d of %0d ok, %0d errors", pass_cnt, NUM_VECS, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hdl/action_engine.sv
`timescale 1ns/1ns
module action_engine (
    input  logic                axis_clk,
    input  logic                aresetn,
    input  action_pkg::action_t action_in,
    input  logic                action_in_valid,
    input  action_pkg::phv_t    phv_in,
    output action_pkg::phv_t    phv_out,
    output logic                phv_out_valid
);

    import action_pkg::*;

    logic                 loc_valid;
    located_t             loc;
    logic                 fet_valid;
    fetched_t             fet;
    logic                 wr_en;
    logic [KV_ADDR_W-1:0] wr_addr;
    logic [KV_DATA_W-1:0] wr_data;
    logic [KV_ADDR_W-1:0] rd_addr;
    logic [KV_DATA_W-1:0] rd_data;

    // stage 1
    operand_locator i_locator (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .action_in       (action_in),
        .phv_in          (phv_in),
        .action_in_valid (action_in_valid),
        .loc_valid       (loc_valid),
        .loc             (loc)
    );

    // stage 2
    operand_fetch i_fetch (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .loc_valid (loc_valid),
        .loc       (loc),
        .fet_valid (fet_valid),
        .fet       (fet),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr)
    );

    kv_ram i_kv_ram (
        .axis_clk (axis_clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // stage 3
    alu_writeback i_writeback (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .fet_valid     (fet_valid),
        .fet           (fet),
        .rd_data       (rd_data),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid)
    );

endmodule

//--- hdl/alu_writeback.sv
`timescale 1ns/1ns
module alu_writeback (
    input  logic                             axis_clk,
    input  logic                             aresetn,
    input  logic                             fet_valid,
    input  action_pkg::fetched_t             fet,
    input  logic [action_pkg::KV_DATA_W-1:0] rd_data,
    output action_pkg::phv_t                 phv_out,
    output logic                             phv_out_valid
);

    import action_pkg::*;

    phv_t     result;
    operand_t sum;
    operand_t diff;

    assign sum  = fet.op1 + fet.op2;
    assign diff = fet.op1 - fet.op2;

    always_comb begin
        result = fet.phv;
        case (fet.act.opcode)
            op_add, op_addi: begin
                result.hdr = field_put(fet.phv.hdr, fet.op1_off, fet.width, sum);
            end
            op_sub, op_subi: begin
                result.hdr = field_put(fet.phv.hdr, fet.op1_off, fet.width, diff);
            end
            // rd_data belongs to this load, read issued one edge ago
            op_load: begin
                result.hdr = field_put(fet.phv.hdr, fet.op1_off, w4, operand_t'(rd_data));
            end
            op_redirect: begin
                result.meta.port = act_port(fet.act);
            end
            op_discard: begin
                result.meta.drop = act_drop(fet.act);
            end
            // store passes the phv through
            default: begin
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            phv_out_valid <= 1'b0;
        end else begin
            phv_out_valid <= fet_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (fet_valid) begin
            phv_out <= result;
        end
    end

endmodule

//--- hdl/kv_ram.sv
`timescale 1ns/1ns
module kv_ram (
    input  logic                             axis_clk,
    input  logic                             wr_en,
    input  logic [action_pkg::KV_ADDR_W-1:0] wr_addr,
    input  logic [action_pkg::KV_DATA_W-1:0] wr_data,
    input  logic [action_pkg::KV_ADDR_W-1:0] rd_addr,
    output logic [action_pkg::KV_DATA_W-1:0] rd_data
);

    import action_pkg::*;

    logic [KV_DATA_W-1:0] mem [KV_DEPTH];

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read-first, one cycle latency
    always_ff @(posedge axis_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/operand_fetch.sv
`timescale 1ns/1ns
module operand_fetch (
    input  logic                                  axis_clk,
    input  logic                                  aresetn,
    input  logic                                  loc_valid,
    input  action_pkg::located_t                  loc,
    output logic                                  fet_valid,
    output action_pkg::fetched_t                  fet,
    output logic                                  wr_en,
    output logic [action_pkg::KV_ADDR_W-1:0]      wr_addr,
    output logic [action_pkg::KV_DATA_W-1:0]      wr_data,
    output logic [action_pkg::KV_ADDR_W-1:0]      rd_addr
);

    import action_pkg::*;

    operand_t op1;
    operand_t op2;

    always_comb begin
        op1 = field_get(loc.phv.hdr, loc.op1_off, loc.width);
        case (loc.act.opcode)
            op_add, op_sub: begin
                op2 = field_get(loc.phv.hdr, loc.op2_off, loc.width);
            end
            op_addi, op_subi: begin
                op2 = operand_t'(act_imm(loc.act));
            end
            default: begin
                op2 = '0;
            end
        endcase
    end

    // memory ports work off the stage 2 contents, so the store lands
    // at the edge the action leaves this stage
    assign wr_en   = loc_valid && (loc.act.opcode == op_store);
    assign wr_addr = act_kv_addr(loc.act);
    assign wr_data = op1[KV_DATA_W-1:0];
    assign rd_addr = act_kv_addr(loc.act);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            fet_valid <= 1'b0;
        end else begin
            fet_valid <= loc_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (loc_valid) begin
            fet.act     <= loc.act;
            fet.phv     <= loc.phv;
            fet.op1_off <= loc.op1_off;
            fet.width   <= loc.width;
            fet.op1     <= op1;
            fet.op2     <= op2;
        end
    end

endmodule

//--- hdl/operand_locator.sv
`timescale 1ns/1ns
module operand_locator (
    input  logic                axis_clk,
    input  logic                aresetn,
    input  action_pkg::action_t action_in,
    input  action_pkg::phv_t    phv_in,
    input  logic                action_in_valid,
    output logic                loc_valid,
    output action_pkg::located_t loc
);

    import action_pkg::*;

    located_t nxt;
    logic     supported;

    function automatic off_t slot_off(off_tbl_t tbl, width_t w, logic [2:0] slot);
        case (w)
            w4:      return tbl.off4[slot];
            w8:      return tbl.off8[slot];
            default: return tbl.off2[slot];
        endcase
    endfunction

    always_comb begin
        nxt.act     = action_in;
        nxt.phv     = phv_in;
        nxt.op1_off = slot_off(phv_in.tbl, action_in.op1_width, action_in.op1_slot);
        nxt.op2_off = '0;
        nxt.width   = action_in.op1_width;
        supported   = 1'b1;
        case (action_in.opcode)
            op_add, op_sub: begin
                nxt.op2_off = slot_off(phv_in.tbl, action_in.op2_width, action_in.op2_slot);
            end
            // only op1 matters here
            op_addi, op_subi, op_redirect, op_discard: begin
            end
            // memory ops always move a 4-byte field
            op_load, op_store: begin
                nxt.width = w4;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            loc_valid <= 1'b0;
        end else begin
            loc_valid <= action_in_valid && supported;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (action_in_valid) begin
            loc <= nxt;
        end
    end

endmodule

//--- hdl/action_pkg.sv
package action_pkg;

    localparam int HDR_BYTES = 64;
    localparam int HDR_BITS  = HDR_BYTES * 8;
    localparam int OFF_SLOTS = 8;
    localparam int KV_DEPTH  = 32;
    localparam int KV_ADDR_W = 5;
    localparam int KV_DATA_W = 32;
    localparam int OPERAND_W = 64;
    localparam int ACTION_W  = 25;

    typedef enum logic [3:0] {
        op_add      = 4'd1,
        op_sub      = 4'd2,
        op_addi     = 4'd3,
        op_subi     = 4'd4,
        op_load     = 4'd5,
        op_store    = 4'd6,
        op_redirect = 4'd8,
        op_discard  = 4'd9
    } opcode_t;

    typedef enum logic [1:0] {
        w2 = 2'd0,
        w4 = 2'd1,
        w8 = 2'd2
    } width_t;

    typedef struct packed {
        opcode_t               opcode;
        width_t                op1_width;
        logic [2:0]            op1_slot;
        width_t                op2_width;
        logic [2:0]            op2_slot;
        logic [ACTION_W-15:0]  low;
    } action_t;

    typedef struct packed {
        logic [7:0]  port;
        logic        drop;
        logic [22:0] rsvd;
    } meta_t;

    typedef logic [7:0]           off_t;
    typedef logic [HDR_BITS-1:0]  hdr_t;
    typedef logic [OPERAND_W-1:0] operand_t;

    // slot 0 of each table sits at the top
    typedef struct packed {
        off_t [0:OFF_SLOTS-1] off2;
        off_t [0:OFF_SLOTS-1] off4;
        off_t [0:OFF_SLOTS-1] off8;
    } off_tbl_t;

    // header byte 0 is the most significant byte
    typedef struct packed {
        hdr_t     hdr;
        off_tbl_t tbl;
        meta_t    meta;
    } phv_t;

    typedef struct packed {
        action_t act;
        phv_t    phv;
        off_t    op1_off;
        off_t    op2_off;
        width_t  width;
    } located_t;

    typedef struct packed {
        action_t  act;
        phv_t     phv;
        off_t     op1_off;
        width_t   width;
        operand_t op1;
        operand_t op2;
    } fetched_t;

    // overlapping views of the action bits
    function automatic logic [15:0] act_imm(action_t a);
        return a[15:0];
    endfunction

    function automatic logic [7:0] act_port(action_t a);
        return a[ACTION_W-5 -: 8];
    endfunction

    function automatic logic act_drop(action_t a);
        return a[ACTION_W-13];
    endfunction

    function automatic logic [KV_ADDR_W-1:0] act_kv_addr(action_t a);
        return a[KV_ADDR_W-1:0];
    endfunction

    // big-endian field read, zero-extended
    function automatic operand_t field_get(hdr_t hdr, off_t off, width_t w);
        hdr_t sh;
        sh = hdr << {off, 3'b000};
        case (w)
            w4:      return operand_t'(sh[HDR_BITS-1 -: 32]);
            w8:      return operand_t'(sh[HDR_BITS-1 -: 64]);
            default: return operand_t'(sh[HDR_BITS-1 -: 16]);
        endcase
    endfunction

    // write the low bytes of val over the field, rest of the header kept
    function automatic hdr_t field_put(hdr_t hdr, off_t off, width_t w, operand_t val);
        hdr_t mask;
        hdr_t data;
        case (w)
            w4: begin
                mask = hdr_t'({32{1'b1}}) << (HDR_BITS - 32);
                data = hdr_t'(val[31:0]) << (HDR_BITS - 32);
            end
            w8: begin
                mask = hdr_t'({64{1'b1}}) << (HDR_BITS - 64);
                data = hdr_t'(val[63:0]) << (HDR_BITS - 64);
            end
            default: begin
                mask = hdr_t'({16{1'b1}}) << (HDR_BITS - 16);
                data = hdr_t'(val[15:0]) << (HDR_BITS - 16);
            end
        endcase
        mask = mask >> {off, 3'b000};
        data = data >> {off, 3'b000};
        return (hdr & ~mask) | (data & mask);
    endfunction

endpackage
